// File: Bender.yml
package:
  name: spi_master

sources:
  - logic/spi_pkg.sv
  - logic/spi_ctrl_if.sv
  - logic/spi_regs.sv
  - logic/spi_clock_gen.sv
  - logic/spi_shifter.sv
  - logic/spi_top.sv
  - target: simulation
    files:
      - bench/spi_slave_model.sv
      - bench/spi_tb.sv

// File: bench/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model #(
	parameter int data_w = 8
) (
	input logic cs_n,
	input logic sck,
	input logic mosi,
	input logic cpol,
	input logic cpha,
	input logic [data_w-1:0] tx_word,
	output logic miso,
	output logic [data_w-1:0] rx_word
);

logic cs_n_d;
logic mosi_d;
logic [data_w-1:0] out_q;
logic leading;

// delayed copies keep the level from before an edge that moves them together.
assign #1 cs_n_d = cs_n;
assign #1 mosi_d = mosi;

initial begin
	miso = 1'b0;
	rx_word = '0;
	out_q = '0;
end

always @(negedge cs_n) begin
	out_q = tx_word;
	rx_word = '0;
	if (!cpha)
		miso = out_q[data_w-1];   // msb ready before the first edge.
end

always @(sck) begin
	if (!cs_n_d) begin
		leading = (sck != cpol);
		if (leading != cpha) begin
			rx_word = {rx_word[data_w-2:0], mosi_d};   // sampling edge.
		end else if (cpha) begin
			miso = out_q[data_w-1];
			out_q = out_q << 1;
		end else begin
			out_q = out_q << 1;
			miso = out_q[data_w-1];
		end
	end
end

endmodule

// File: bench/spi_tb.sv
`timescale 1ns/1ps

module spi_tb;
import spi_pkg::*;

localparam int data_w = data_w_default;
localparam int timeout_cycles = 400;

logic clk;
logic n_reset;
logic bus_we;
logic bus_oe;
logic periph_sel;
logic [addr_w-1:0] periph_addr;
wire [data_w-1:0] bus_data;
logic [data_w-1:0] bus_drive;
logic bus_drive_en;
logic interrupt;
logic miso;
logic cs_n;
logic mosi;
logic sck;
logic slave_cpol;
logic slave_cpha;
logic [data_w-1:0] slave_tx;
logic [data_w-1:0] slave_rx;

assign bus_data = bus_drive_en ? bus_drive : {data_w{1'bz}};

spi_top #(.data_w(data_w), .prescale_w(prescale_w_default)) i_spi_top (
	.clk(clk),
	.n_reset(n_reset),
	.bus_we(bus_we),
	.bus_oe(bus_oe),
	.periph_sel(periph_sel),
	.periph_addr(periph_addr),
	.bus_data(bus_data),
	.interrupt(interrupt),
	.miso(miso),
	.cs_n(cs_n),
	.mosi(mosi),
	.sck(sck)
);

spi_slave_model #(.data_w(data_w)) i_spi_slave_model (
	.cs_n(cs_n),
	.sck(sck),
	.mosi(mosi),
	.cpol(slave_cpol),
	.cpha(slave_cpha),
	.tx_word(slave_tx),
	.miso(miso),
	.rx_word(slave_rx)
);

always #50 clk = ~clk;

task automatic abort_test();
	$display("TEST RESULT: FAIL");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic report_timeout(input string what);
	$display("timeout at %0t: %s", $time, what);
	abort_test();
endtask

task automatic check_word(input string what, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
	if (got !== exp) begin
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		abort_test();
	end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		abort_test();
	end
endtask

task automatic check_count(input string what, input int got, input int exp, input int slack);
	if (got < exp - slack || got > exp + slack) begin
		$display("ERR %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
		abort_test();
	end
endtask

// control word assembled from its fields with the unused bit at zero.
function automatic logic [data_w-1:0] ctrl_word(input logic en, input logic ie,
		input logic cpol, input logic cpha, input logic [ctrl_div_w-1:0] div);
	ctrl_word = '0;
	ctrl_word[ctrl_en] = en;
	ctrl_word[ctrl_ie] = ie;
	ctrl_word[ctrl_cpol] = cpol;
	ctrl_word[ctrl_cpha] = cpha;
	ctrl_word[ctrl_div +: ctrl_div_w] = div;
endfunction

task automatic bus_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
	@(negedge clk);
	periph_sel = 1'b1;
	bus_we = 1'b1;
	periph_addr = addr;
	bus_drive = data;
	bus_drive_en = 1'b1;
	@(negedge clk);
	periph_sel = 1'b0;
	bus_we = 1'b0;
	bus_drive_en = 1'b0;
endtask

task automatic bus_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
	@(negedge clk);
	periph_sel = 1'b1;
	bus_oe = 1'b1;
	periph_addr = addr;
	@(negedge clk);
	data = bus_data;
	periph_sel = 1'b0;
	bus_oe = 1'b0;
endtask

task automatic wait_done();
	logic [data_w-1:0] stat;
	int polls;
	stat = '0;
	polls = 0;
	while (stat[stat_done] !== 1'b1) begin
		if (polls == timeout_cycles)
			report_timeout("done flag never set");
		bus_read(spi_stat_addr, stat);
		polls++;
	end
endtask

// counts falling clk edges until cs_n reaches the level.
task automatic wait_cs_n(input logic level, output int cycles);
	cycles = 0;
	while (cs_n !== level) begin
		if (cycles == timeout_cycles)
			report_timeout("cs_n did not change");
		@(negedge clk);
		cycles++;
	end
endtask

task automatic run_transfer(input logic cpol, input logic cpha,
		input logic [ctrl_div_w-1:0] div, input logic ie);
	logic [data_w-1:0] tx;
	logic [data_w-1:0] rd;
	int cycles;
	tx = data_w'($urandom);
	slave_tx = data_w'($urandom);
	slave_cpol = cpol;
	slave_cpha = cpha;
	bus_write(spi_ctrl_addr, ctrl_word(1'b1, ie, cpol, cpha, div));
	check_bit("sck idle", sck, cpol);
	bus_write(spi_data_addr, tx);
	wait_cs_n(1'b0, cycles);
	check_bit("interrupt during transfer", interrupt, 1'b0);
	wait_cs_n(1'b1, cycles);
	check_count("transfer length", cycles, 2 * data_w * (1 << div), 1);
	check_bit("sck idle after transfer", sck, cpol);
	wait_done();
	check_word("slave received", slave_rx, tx);
	bus_read(spi_data_addr, rd);
	check_word("data register", rd, slave_tx);
	bus_read(2'd3, rd);
	check_word("address 3 after transfer", rd, '0);
	check_bit("interrupt at completion", interrupt, ie);
endtask

task automatic test_reset_state();
	logic [data_w-1:0] rd;
	check_bit("cs_n", cs_n, 1'b1);
	check_bit("interrupt", interrupt, 1'b0);
	check_bit("sck", sck, 1'b0);
	bus_read(spi_stat_addr, rd);
	check_word("status after reset", rd, '0);
	bus_read(spi_ctrl_addr, rd);
	check_word("control after reset", rd, '0);
	bus_read(spi_data_addr, rd);
	check_word("data after reset", rd, '0);
endtask

task automatic test_register_access();
	logic [data_w-1:0] v;
	logic [data_w-1:0] rd;
	for (int i = 0; i < 5; i++) begin
		v = (i == 0) ? '1 : data_w'($urandom);
		bus_write(spi_ctrl_addr, v);
		bus_read(spi_ctrl_addr, rd);
		check_word("control readback", rd, ctrl_word(v[ctrl_en], v[ctrl_ie],
			v[ctrl_cpol], v[ctrl_cpha], v[ctrl_div +: ctrl_div_w]));
	end
	bus_write(spi_ctrl_addr, '1);
	bus_read(2'd3, rd);
	check_word("address 3", rd, '0);
	bus_write(spi_ctrl_addr, '0);
	@(negedge clk);
	bus_oe = 1'b1;   // output enable without select.
	@(negedge clk);
	check_word("bus while unselected", bus_data, 'z);
	bus_oe = 1'b0;
endtask

task automatic test_ignored_starts();
	logic [data_w-1:0] tx;
	logic [data_w-1:0] rd;
	int cycles;
	bus_write(spi_ctrl_addr, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 3'd0));
	bus_write(spi_data_addr, data_w'($urandom));
	repeat (20) begin
		@(negedge clk);
		check_bit("cs_n while disabled", cs_n, 1'b1);
	end
	tx = data_w'($urandom);
	slave_tx = data_w'($urandom);
	slave_cpol = 1'b0;
	slave_cpha = 1'b0;
	bus_write(spi_ctrl_addr, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 3'd2));
	bus_write(spi_data_addr, tx);
	wait_cs_n(1'b0, cycles);
	bus_read(spi_stat_addr, rd);
	check_bit("busy while cs_n low", rd[stat_busy], 1'b1);
	check_bit("cs_n during transfer", cs_n, 1'b0);
	bus_write(spi_data_addr, ~tx);   // must not reach the shifter.
	wait_cs_n(1'b1, cycles);
	wait_done();
	check_word("slave received", slave_rx, tx);
	bus_read(spi_data_addr, rd);
	check_word("data register", rd, slave_tx);
endtask

initial begin
	void'($urandom(9677));
	clk = 1'b0;
	n_reset = 1'b0;
	bus_we = 1'b0;
	bus_oe = 1'b0;
	periph_sel = 1'b0;
	periph_addr = '0;
	bus_drive = '0;
	bus_drive_en = 1'b0;
	slave_cpol = 1'b0;
	slave_cpha = 1'b0;
	slave_tx = '0;
	repeat (5) @(negedge clk);
	n_reset = 1'b1;
	test_reset_state();
	test_register_access();
	for (int mode = 0; mode < 4; mode++) begin
		run_transfer(mode[1], mode[0], 3'd0, 1'b0);
		run_transfer(mode[1], mode[0], 3'd2, 1'b0);
	end
	run_transfer(1'b0, 1'b0, 3'd1, 1'b0);   // timing at further dividers.
	run_transfer(1'b1, 1'b0, 3'd3, 1'b0);
	run_transfer(1'b0, 1'b0, 3'd0, 1'b1);
	bus_write(spi_stat_addr, '0);
	check_bit("interrupt after status write", interrupt, 1'b0);
	run_transfer(1'b1, 1'b1, 3'd0, 1'b1);
	run_transfer(1'b0, 1'b1, 3'd0, 1'b1);   // start clears the pending interrupt.
	run_transfer(1'b0, 1'b0, 3'd0, 1'b0);
	test_ignored_starts();
	$display("TEST RESULT: PASS");
	$finish;
end

endmodule

// File: logic/spi_clock_gen.sv
`timescale 1ns/1ps

module spi_clock_gen #(
	parameter int prescale_w = spi_pkg::prescale_w_default
) (
	input logic clk,
	input logic n_reset,
	input logic run,
	input logic [spi_pkg::ctrl_div_w-1:0] div_sel,
	output logic tick
);

logic [prescale_w-1:0] count;
logic [prescale_w-1:0] mask;

// the low div_sel bits count out one half period.
assign mask = ~({prescale_w{1'b1}} << div_sel);

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		count <= '0;
	end else if (!run) begin
		count <= '0;   // each transfer starts phase-aligned.
	end else begin
		count <= count + 1'b1;
	end
end

// one tick at the end of every half period.
assign tick = run & (&(count | ~mask));

endmodule

// File: logic/spi_ctrl_if.sv
`timescale 1ns/1ps

interface spi_ctrl_if #(
	parameter int data_w = spi_pkg::data_w_default
);
import spi_pkg::*;

// configuration levels.
logic enable;
logic cpol;
logic cpha;
logic [ctrl_div_w-1:0] div_sel;

// transfer control.
logic start;                 // one clk pulse.
logic [data_w-1:0] tx_data;  // valid with start.
logic busy;
logic done;                  // one clk pulse per transfer.
logic [data_w-1:0] rx_data;  // valid at done.

modport regs (
	output enable, cpol, cpha, div_sel, start, tx_data,
	input busy, done, rx_data
);

modport engine (
	input enable, cpol, cpha, div_sel, start, tx_data,
	output busy, done, rx_data
);

endinterface

// File: logic/spi_pkg.sv
package spi_pkg;

localparam int addr_w = 2;
localparam int data_w_default = 8;
localparam int prescale_w_default = 7;

// register map, address 3 reads zero.
localparam logic [addr_w-1:0] spi_ctrl_addr = 2'd0;
localparam logic [addr_w-1:0] spi_stat_addr = 2'd1;
localparam logic [addr_w-1:0] spi_data_addr = 2'd2;

// control register bits.
localparam int ctrl_en = 7;
localparam int ctrl_ie = 6;
localparam int ctrl_cpol = 5;
localparam int ctrl_cpha = 4;
localparam int ctrl_div = 0;   // lsb of the divider field.
localparam int ctrl_div_w = 3;

// bits that read back from the control register.
localparam logic [data_w_default-1:0] ctrl_mask = data_w_default'(
	(1 << ctrl_en) | (1 << ctrl_ie) | (1 << ctrl_cpol) | (1 << ctrl_cpha) |
	(((1 << ctrl_div_w) - 1) << ctrl_div));

// status register bits.
localparam int stat_busy = 0;
localparam int stat_done = 1;   // sticky.

// field order follows the bit positions above.
typedef struct packed {
	logic en;
	logic ie;
	logic cpol;
	logic cpha;
	logic rsvd;
	logic [ctrl_div_w-1:0] div;
} ctrl_fields_t;

// one bus word, seen as control fields or as a raw shift word.
typedef union packed {
	ctrl_fields_t ctrl;
	logic [data_w_default-1:0] raw;
} bus_word_u;

endpackage

// File: logic/spi_regs.sv
`timescale 1ns/1ps

module spi_regs #(
	parameter int data_w = spi_pkg::data_w_default
) (
	input logic clk,
	input logic n_reset,
	input logic bus_we,
	input logic bus_oe,
	input logic periph_sel,
	input logic [spi_pkg::addr_w-1:0] periph_addr,
	input logic [data_w-1:0] write_data,
	output logic [data_w-1:0] read_data,
	output logic interrupt,
	spi_ctrl_if.regs ctl
);
import spi_pkg::*;

logic we;
logic oe;
bus_word_u wr_word;
ctrl_fields_t ctrl_q;
logic start_q;
logic done_q;
logic [data_w-1:0] tx_q;
logic [data_w-1:0] rx_q;
logic idle;
logic done_now;
logic [data_w-1:0] stat_word;
logic [data_w-1:0] rx_word;

assign we = periph_sel & bus_we;
assign oe = periph_sel & bus_oe;
assign wr_word = bus_word_u'(write_data);

// a start already issued counts as busy.
assign idle = ~ctl.busy & ~start_q;

// done and rx are visible in the cycle of the done pulse.
assign done_now = done_q | ctl.done;
assign rx_word = ctl.done ? ctl.rx_data : rx_q;

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		ctrl_q <= '0;
		start_q <= 1'b0;
		done_q <= 1'b0;
		tx_q <= '0;
		rx_q <= '0;
	end else begin
		start_q <= 1'b0;
		if (we && periph_addr == spi_ctrl_addr)
			ctrl_q <= wr_word.ctrl;
		if (we && periph_addr == spi_data_addr && idle) begin
			tx_q <= data_w'(wr_word.raw);
			start_q <= ctrl_q.en;   // disabled, the write only loads tx.
		end
		if (ctl.done)
			done_q <= 1'b1;
		else if (start_q || (we && periph_addr == spi_stat_addr))
			done_q <= 1'b0;
		if (ctl.done)
			rx_q <= ctl.rx_data;
	end
end

always_comb begin
	stat_word = '0;
	stat_word[stat_busy] = ctl.busy;
	stat_word[stat_done] = done_now;
end

always_comb begin
	read_data = '0;
	if (oe) begin
		case (periph_addr)
		spi_ctrl_addr: read_data = data_w'(ctrl_q & ctrl_mask);
		spi_stat_addr: read_data = stat_word;
		spi_data_addr: read_data = rx_word;
		default: read_data = '0;
		endcase
	end
end

assign ctl.enable = ctrl_q.en;
assign ctl.cpol = ctrl_q.cpol;
assign ctl.cpha = ctrl_q.cpha;
assign ctl.div_sel = ctrl_q.div;
assign ctl.start = start_q;
assign ctl.tx_data = tx_q;

assign interrupt = done_now & ctrl_q.ie;   // level, held until cleared.

endmodule

// File: logic/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter #(
	parameter int data_w = spi_pkg::data_w_default
) (
	input logic clk,
	input logic n_reset,
	input logic tick,
	input logic miso,
	output logic run,
	output logic sck,
	output logic mosi,
	output logic cs_n,
	spi_ctrl_if.engine ctl
);

localparam int cnt_w = $clog2(2 * data_w);
localparam logic [cnt_w-1:0] last_half = cnt_w'(2 * data_w - 1);

logic busy_q;
logic done_q;
logic phase_q;
logic [cnt_w-1:0] half_cnt;
logic [data_w-1:0] shift_q;
logic in_bit;
logic sample_edge;
logic last_tick;

// phase 0 at a tick means a leading edge.
assign sample_edge = ~(phase_q ^ ctl.cpha);
assign last_tick = (half_cnt == last_half);

always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		busy_q <= 1'b0;
		done_q <= 1'b0;
		phase_q <= 1'b0;
		half_cnt <= '0;
		shift_q <= '0;
	end else begin
		done_q <= 1'b0;
		if (!busy_q) begin
			if (ctl.start && ctl.enable) begin
				busy_q <= 1'b1;
				phase_q <= 1'b0;
				half_cnt <= '0;
				shift_q <= ctl.tx_data;   // msb is on mosi before the first edge.
			end
		end else if (tick) begin
			phase_q <= ~phase_q;
			half_cnt <= half_cnt + 1'b1;
			if (last_tick) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
			if (sample_edge && last_tick) begin
				// cpha 1 ends on a sampling edge, take miso directly.
				shift_q <= {shift_q[data_w-2:0], miso};
			end else if (!sample_edge && half_cnt != '0) begin
				shift_q <= {shift_q[data_w-2:0], in_bit};
			end
		end
	end
end

// sampled bit waits here for the next shift edge.
always_ff @(posedge clk) begin
	if (busy_q && tick && sample_edge)
		in_bit <= miso;
end

assign run = busy_q;
assign sck = phase_q ^ ctl.cpol;   // idles at cpol.
assign cs_n = ~busy_q;
assign mosi = shift_q[data_w-1];

assign ctl.busy = busy_q;
assign ctl.done = done_q;
assign ctl.rx_data = shift_q;

endmodule

// File: logic/spi_top.sv
`timescale 1ns/1ps

module spi_top #(
	parameter int data_w = spi_pkg::data_w_default,
	parameter int prescale_w = spi_pkg::prescale_w_default
) (
	input logic clk,
	input logic n_reset,
	input logic bus_we,
	input logic bus_oe,
	input logic periph_sel,
	input logic [spi_pkg::addr_w-1:0] periph_addr,
	inout logic [data_w-1:0] bus_data,
	output logic interrupt,
	input logic miso,
	output logic cs_n,
	output logic mosi,
	output logic sck
);

logic [data_w-1:0] read_data;
logic run;
logic tick;

spi_ctrl_if #(.data_w(data_w)) ctl ();

// shared bus, driven only while this peripheral is read.
assign bus_data = (periph_sel & bus_oe) ? read_data : {data_w{1'bz}};

spi_regs #(.data_w(data_w)) i_spi_regs (
	.clk(clk),
	.n_reset(n_reset),
	.bus_we(bus_we),
	.bus_oe(bus_oe),
	.periph_sel(periph_sel),
	.periph_addr(periph_addr),
	.write_data(bus_data),
	.read_data(read_data),
	.interrupt(interrupt),
	.ctl(ctl.regs)
);

spi_clock_gen #(.prescale_w(prescale_w)) i_spi_clock_gen (
	.clk(clk),
	.n_reset(n_reset),
	.run(run),
	.div_sel(ctl.div_sel),
	.tick(tick)
);

spi_shifter #(.data_w(data_w)) i_spi_shifter (
	.clk(clk),
	.n_reset(n_reset),
	.tick(tick),
	.miso(miso),
	.run(run),
	.sck(sck),
	.mosi(mosi),
	.cs_n(cs_n),
	.ctl(ctl.engine)
);

endmodule

// File: sim.f
logic/spi_pkg.sv
logic/spi_ctrl_if.sv
logic/spi_regs.sv
logic/spi_clock_gen.sv
logic/spi_shifter.sv
logic/spi_top.sv
bench/spi_slave_model.sv
bench/spi_tb.sv
